/* all.f */
+incdir+include
src/sudoku_geom_pkg.sv
src/solver_ctrl_pkg.sv
src/grid_access_if.sv
src/sudoku_cell.sv
src/cell_array.sv
src/constraint_sweep.sv
src/sudoku_solver.sv
verification/tb_sudoku_solver.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_sudoku_solver -f all.f

status=0
./obj_dir/Vtb_sudoku_solver > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Simulation finished: FAIL" sim.log; then
  echo "simulation failed, see sim.log"
  exit 1
fi
if ! grep -q "Simulation finished: PASS" sim.log; then
  echo "simulation ended without a result, see sim.log"
  exit 1
fi

/* include/tb_puzzles.svh */
`ifndef TB_PUZZLES_SVH
`define TB_PUZZLES_SVH

typedef enum {OUT_SOLVED, OUT_STUCK, OUT_ILLEGAL, OUT_ABORT} outcome_e;

localparam int NUM_PUZZLES = 4;

string puzzle_name [NUM_PUZZLES] = '{
  "elim_solvable", "needs_guess", "empty_cell", "abort_mid_solve"
};

outcome_e puzzle_outcome [NUM_PUZZLES] = '{
  OUT_SOLVED, OUT_STUCK, OUT_ILLEGAL, OUT_ABORT
};

// givens per row, one digit per column from column 0, 0 is a blank
// one band of three rows per line
string puzzle_givens [NUM_PUZZLES][GRID_DIM] = '{
  '{"003456789", "406789123", "780123456",
    "234067891", "567001234", "891230567",
    "345678012", "678912305", "912345670"},
  '{"123456789", "000000000", "000000000",
    "000000000", "000891000", "000000000",
    "000000000", "000000000", "900000008"},
  // box 2 of band 0 ends up without 8 or 9 for two open cells
  '{"123456700", "000000890", "000000000",
    "000000000", "000000000", "000000000",
    "000000000", "000000000", "000000000"},
  '{"123456789", "000000000", "000000000",
    "000000000", "000891000", "000000000",
    "000000000", "000000000", "900000008"}
};

// full grid, only where elimination alone finishes the puzzle
string puzzle_solution [NUM_PUZZLES][GRID_DIM] = '{
  '{"123456789", "456789123", "789123456",
    "234567891", "567891234", "891234567",
    "345678912", "678912345", "912345678"},
  '{"", "", "", "", "", "", "", "", ""},
  '{"", "", "", "", "", "", "", "", ""},
  '{"", "", "", "", "", "", "", "", ""}
};

`endif

/* verification/tb_sudoku_solver.sv */
module tb_sudoku_solver;
  timeunit 1ns;
  timeprecision 100ps;
  import sudoku_geom_pkg::*;
  import solver_ctrl_pkg::*;

  `include "tb_puzzles.svh"

  logic clk = 1'b0;
  logic reset;
  row_addr_t row_addr;
  third_en_t third_en;
  logic mask_write;
  row_data_t wdata;
  row_data_t rdata;
  logic start_solve;
  logic abort;
  logic busy;
  logic solved;
  logic stuck;
  logic illegal;

  int row_errors = 0;
  int flag_errors = 0;
  int outcome_errors = 0;
  int seed = 96;
  cand_t model [GRID_DIM][GRID_DIM]; // reference grid

  always #50 clk = ~clk;

  sudoku_solver DUT (
    .clk           (clk),
    .reset         (reset),
    .row_addr_i    (row_addr),
    .third_en_i    (third_en),
    .mask_write_i  (mask_write),
    .wdata_i       (wdata),
    .rdata_o       (rdata),
    .start_solve_i (start_solve),
    .abort_i       (abort),
    .busy_o        (busy),
    .solved_o      (solved),
    .stuck_o       (stuck),
    .illegal_o     (illegal)
  );

  task automatic tick();
    @(posedge clk);
    #5;
  endtask

  task automatic write_row(input int r, input third_en_t te, input logic mw, input row_data_t d);
    row_addr = row_addr_t'(r);
    third_en = te;
    mask_write = mw;
    wdata = d;
    tick();
    third_en = '0;
    mask_write = 1'b0;
  endtask

  task automatic read_row(input int r, output row_data_t d);
    row_addr = row_addr_t'(r);
    #40; // sample late in the cycle
    d = rdata;
    tick();
  endtask

  task automatic check_row(input string name, input int r, input row_data_t expected,
                           input row_data_t actual);
    if (actual !== expected) begin
      row_errors++;
      $display("** Error %s row %0d: expected %h, actual %h", name, r, expected, actual);
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      flag_errors++;
      $display("** Error %s: expected %b, actual %b", name, expected, actual);
    end
  endtask

  task automatic check_outcome(input string name, input outcome_e expected,
                               input outcome_e actual);
    if (actual != expected) begin
      outcome_errors++;
      $display("** Error %s outcome: expected %s, actual %s", name, expected.name(),
               actual.name());
    end
  endtask

  // blank becomes all nine candidates, a digit a single one
  function automatic row_data_t digits_to_row(string s);
    row_data_t row;
    int d;
    for (int c = 0; c < GRID_DIM; c++) begin
      d = s[c] - "0";
      row[c] = (d == 0) ? ALL_CANDIDATES : cand_t'(1) << (d - 1);
    end
    return row;
  endfunction

  // strike settled digits from every open peer until nothing moves
  function automatic void run_model();
    cand_t seen;
    bit changed;
    changed = 1'b1;
    while (changed) begin
      changed = 1'b0;
      for (int r = 0; r < GRID_DIM; r++) begin
        for (int c = 0; c < GRID_DIM; c++) begin
          seen = '0;
          for (int r2 = 0; r2 < GRID_DIM; r2++) begin
            for (int c2 = 0; c2 < GRID_DIM; c2++) begin
              if ((r2 == r || c2 == c || (r2 / BOX_DIM == r / BOX_DIM &&
                   c2 / BOX_DIM == c / BOX_DIM)) && $onehot(model[r2][c2])) begin
                seen |= model[r2][c2];
              end
            end
          end
          if (!$onehot(model[r][c]) && (model[r][c] & seen) != '0) begin
            model[r][c] &= ~seen;
            changed = 1'b1;
          end
        end
      end
    end
  endfunction

  task automatic abort_solve(input string name);
    int delay;
    delay = 1 + ($unsigned($random(seed)) % 30);
    row_addr = '0;
    wdata = '0;
    third_en = '1; // a load of zeros that must not land while busy
    #40;
    check_row({name, " readback while busy"}, 0, '1, rdata);
    tick();
    third_en = '0;
    repeat (delay - 1) tick();
    abort = 1'b1;
    tick();
    abort = 1'b0;
    if (busy) begin
      tick();
    end
    check_flag({name, " busy within 2 cycles of abort"}, 1'b0, busy);
  endtask

  task automatic run_puzzle(input int p);
    string name;
    row_data_t want;
    row_data_t got;
    outcome_e outcome;
    name = puzzle_name[p];
    for (int r = 0; r < GRID_DIM; r++) begin
      want = digits_to_row(puzzle_givens[p][r]);
      write_row(r, '1, 1'b0, want);
      for (int c = 0; c < GRID_DIM; c++) begin
        model[r][c] = want[c];
      end
    end
    start_solve = 1'b1;
    tick();
    start_solve = 1'b0;
    check_flag({name, " busy after start"}, 1'b1, busy);
    if (puzzle_outcome[p] == OUT_ABORT) begin
      abort_solve(name);
    end
    while (busy) begin
      tick();
    end
    outcome = solved ? OUT_SOLVED : illegal ? OUT_ILLEGAL : stuck ? OUT_STUCK : OUT_ABORT;
    check_outcome(name, puzzle_outcome[p], outcome);
    check_flag({name, " solved"}, puzzle_outcome[p] == OUT_SOLVED, solved);
    check_flag({name, " stuck"}, puzzle_outcome[p] inside {OUT_STUCK, OUT_ILLEGAL}, stuck);
    check_flag({name, " illegal"}, puzzle_outcome[p] == OUT_ILLEGAL, illegal);
    run_model();
    for (int r = 0; r < GRID_DIM; r++) begin
      read_row(r, got);
      for (int c = 0; c < GRID_DIM; c++) begin
        want[c] = model[r][c];
      end
      if (puzzle_outcome[p] == OUT_SOLVED) begin
        want = digits_to_row(puzzle_solution[p][r]);
      end
      // after an abort only the fully given top row is known
      if (puzzle_outcome[p] != OUT_ILLEGAL && (puzzle_outcome[p] != OUT_ABORT || r == 0)) begin
        check_row(name, r, want, got);
      end
    end
    if (puzzle_outcome[p] == OUT_SOLVED) begin
      start_solve = 1'b1;
      tick();
      start_solve = 1'b0;
      check_flag({name, " busy on start while solved"}, 1'b0, busy);
      tick();
      check_flag({name, " busy stays low while solved"}, 1'b0, busy);
    end
  endtask

  initial begin
    row_data_t pattern;
    row_data_t want;
    row_data_t got;
    reset = 1'b1;
    row_addr = '0;
    third_en = '0;
    mask_write = 1'b0;
    wdata = '0;
    start_solve = 1'b0;
    abort = 1'b0;
    repeat (3) @(posedge clk);
    #5;
    reset = 1'b0;

    check_flag("reset busy", 1'b0, busy);
    check_flag("reset solved", 1'b0, solved);
    check_flag("reset stuck", 1'b0, stuck);
    check_flag("reset illegal", 1'b0, illegal);
    for (int r = 0; r < GRID_DIM; r++) begin
      read_row(r, got);
      check_row("reset readback", r, '1, got);
    end

    // row te gets third_en te and every loaded cell ends up fixed
    for (int te = 0; te < 8; te++) begin
      for (int c = 0; c < GRID_DIM; c++) begin
        pattern[c] = cand_t'(1) << ((te + c) % GRID_DIM);
        want[c] = te[c / BOX_DIM] ? pattern[c] : ALL_CANDIDATES;
      end
      write_row(te, third_en_t'(te), 1'b0, pattern);
      read_row(te, got);
      check_row("third enable load", te, want, got);
    end

    // thirds 0 and 1 of row 3 hold single digits while third 2 is still open
    for (int c = 0; c < GRID_DIM; c++) begin
      pattern[c] = ~(cand_t'(1) << ((3 + c) % GRID_DIM));
      want[c] = (c < 2 * BOX_DIM) ? cand_t'(1) << ((3 + c) % GRID_DIM) : pattern[c];
    end
    write_row(3, '1, 1'b1, pattern);
    read_row(3, got);
    check_row("mask write", 3, want, got);

    for (int p = 0; p < NUM_PUZZLES; p++) begin
      run_puzzle(p);
    end

    $display("errors: %0d row, %0d flag, %0d outcome", row_errors, flag_errors,
             outcome_errors);
    if (row_errors + flag_errors + outcome_errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // every puzzle gets 50 full passes
  initial begin
    #(NUM_PUZZLES * 50 * PASS_CYCLES * 100);
    $display("timeout: the solver did not finish its puzzles in time");
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

/* src/sudoku_solver.sv */
module sudoku_solver (
  input  logic clk,
  input  logic reset,
  input  sudoku_geom_pkg::row_addr_t row_addr_i,
  input  sudoku_geom_pkg::third_en_t third_en_i,
  input  logic mask_write_i,
  input  sudoku_geom_pkg::row_data_t wdata_i,
  output sudoku_geom_pkg::row_data_t rdata_o,
  input  logic start_solve_i,
  input  logic abort_i,
  output logic busy_o,
  output logic solved_o,
  output logic stuck_o,
  output logic illegal_o
);
  import sudoku_geom_pkg::*;

  grid_access_if host_if ();
  grid_access_if sweep_if ();

  logic progress;
  logic any_empty;
  logic latch_progress;

  // rows past the grid select nothing
  assign host_if.row_sel = (row_addr_i < GRID_DIM) ? row_sel_t'(1) << row_addr_i : '0;
  assign host_if.third_en = third_en_i;
  assign host_if.mask_write = mask_write_i;
  assign host_if.wdata = wdata_i;

  assign rdata_o = busy_o ? '1 : host_if.rdata; // grid is in flux while solving

  cell_array u_cell_array (
    .clk              (clk),
    .reset            (reset),
    .host             (host_if.array),
    .sweep            (sweep_if.array),
    .busy_i           (busy_o),
    .latch_progress_i (latch_progress),
    .progress_o       (progress),
    .any_empty_o      (any_empty),
    .all_fixed_o      (solved_o)
  );

  constraint_sweep u_sweep (
    .clk              (clk),
    .reset            (reset),
    .access           (sweep_if.sweeper),
    .start_solve_i    (start_solve_i),
    .abort_i          (abort_i),
    .progress_i       (progress),
    .any_empty_i      (any_empty),
    .all_fixed_i      (solved_o),
    .busy_o           (busy_o),
    .latch_progress_o (latch_progress),
    .stuck_o          (stuck_o),
    .illegal_o        (illegal_o)
  );

endmodule

/* src/constraint_sweep.sv */
module constraint_sweep (
  input  logic clk,
  input  logic reset,
  grid_access_if.sweeper access,
  input  logic start_solve_i,
  input  logic abort_i,
  input  logic progress_i,
  input  logic any_empty_i,
  input  logic all_fixed_i,
  output logic busy_o,
  output logic latch_progress_o,
  output logic stuck_o,
  output logic illegal_o
);
  import sudoku_geom_pkg::*;
  import solver_ctrl_pkg::*;

  sweep_state_t state;
  row_sel_t row_ptr; // one-hot, row being scanned
  logic first_pass;

  cand_t col_mask [GRID_DIM];
  cand_t box_mask [BOX_DIM];
  cand_t row_mask;

  cand_t scan_fixed [GRID_DIM]; // settled digits of the row on rdata
  cand_t box_scan [BOX_DIM];
  cand_t scan_row;

  logic writing;
  logic done_exit;
  logic stall_exit;

  // only a cell with a single candidate eliminates anything
  function automatic cand_t fixed_digit(cand_t c);
    return $onehot(c) ? c : '0;
  endfunction

  always_comb begin
    scan_row = ALL_CANDIDATES;
    for (int b = 0; b < BOX_DIM; b++) begin
      box_scan[b] = ALL_CANDIDATES;
    end
    for (int c = 0; c < GRID_DIM; c++) begin
      scan_fixed[c] = fixed_digit(access.rdata[c]);
      scan_row = scan_row & ~scan_fixed[c];
      box_scan[c / BOX_DIM] = box_scan[c / BOX_DIM] & ~scan_fixed[c];
    end
  end

  assign busy_o = (state != S_IDLE);
  assign latch_progress_o = (state == S_CHECK);
  assign writing = state inside {S_ROW_SAVE, S_BOX_SAVE, S_COL_SAVE};

  assign done_exit = all_fixed_i | any_empty_i | abort_i;
  assign stall_exit = (state == S_CHECK) && !progress_i && !first_pass;

  assign access.third_en = {BOX_DIM{writing}};
  assign access.mask_write = writing;

  always_comb begin
    access.row_sel = '0;
    access.wdata = '0;
    unique case (state)
      S_ROW_SCAN: access.row_sel = row_ptr;
      S_ROW_SAVE: begin
        access.row_sel = row_ptr;
        access.wdata = {GRID_DIM{row_mask}};
      end
      S_BOX_SAVE: begin
        access.row_sel = row_ptr | (row_ptr >> 1) | (row_ptr >> 2); // whole band
        for (int c = 0; c < GRID_DIM; c++) begin
          access.wdata[c] = box_mask[c / BOX_DIM];
        end
      end
      S_COL_SAVE: begin
        access.row_sel = '1;
        for (int c = 0; c < GRID_DIM; c++) begin
          access.wdata[c] = col_mask[c];
        end
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= S_IDLE;
      row_ptr <= '0;
      first_pass <= 1'b0;
      stuck_o <= 1'b0;
      illegal_o <= 1'b0;
    end else if (busy_o) begin
      if (done_exit) begin
        stuck_o <= any_empty_i; // an illegal grid reads as stuck too
        illegal_o <= any_empty_i;
        row_ptr <= '0;
        state <= S_IDLE;
      end else begin
        unique case (state)
          S_CHECK: begin
            if (stall_exit) begin
              stuck_o <= 1'b1;
              state <= S_IDLE;
            end else begin
              first_pass <= 1'b0;
              row_ptr <= row_sel_t'(1);
              state <= S_ROW_SCAN;
            end
          end
          S_ROW_SCAN: state <= S_ROW_SAVE;
          S_ROW_SAVE: begin
            if ((row_ptr & BAND_LAST_ROWS) != '0) begin
              state <= S_BOX_SAVE;
            end else begin
              row_ptr <= row_ptr << 1;
              state <= S_ROW_SCAN;
            end
          end
          S_BOX_SAVE: begin
            if (row_ptr[GRID_DIM-1]) begin
              state <= S_COL_SAVE;
            end else begin
              row_ptr <= row_ptr << 1;
              state <= S_ROW_SCAN;
            end
          end
          S_COL_SAVE: begin
            row_ptr <= '0;
            state <= S_CHECK;
          end
          default: state <= S_IDLE;
        endcase
      end
    end else if (start_solve_i && !all_fixed_i) begin
      stuck_o <= 1'b0;
      illegal_o <= 1'b0;
      first_pass <= 1'b1; // progress from host writes means nothing yet
      state <= S_CHECK;
    end
  end

  always_ff @(posedge clk) begin
    if (state == S_CHECK) begin
      for (int c = 0; c < GRID_DIM; c++) begin
        col_mask[c] <= ALL_CANDIDATES;
      end
      for (int b = 0; b < BOX_DIM; b++) begin
        box_mask[b] <= ALL_CANDIDATES;
      end
    end else if (state == S_ROW_SCAN) begin
      row_mask <= scan_row;
      for (int c = 0; c < GRID_DIM; c++) begin
        col_mask[c] <= col_mask[c] & ~scan_fixed[c];
      end
      for (int b = 0; b < BOX_DIM; b++) begin
        box_mask[b] <= box_mask[b] & box_scan[b];
      end
    end else if (state == S_BOX_SAVE) begin
      for (int b = 0; b < BOX_DIM; b++) begin
        box_mask[b] <= ALL_CANDIDATES; // next band starts clean
      end
    end
  end

  a_row_onehot: assert property (
    @(posedge clk) disable iff (reset)
    (state inside {S_ROW_SCAN, S_ROW_SAVE}) |-> $onehot0(access.row_sel)
  );

  a_busy_exit: assert property (
    @(posedge clk) disable iff (reset)
    $fell(busy_o) |-> $past(done_exit || stall_exit)
  );

endmodule

/* src/cell_array.sv */
module cell_array (
  input  logic clk,
  input  logic reset,
  grid_access_if.array host,
  grid_access_if.array sweep,
  input  logic busy_i,
  input  logic latch_progress_i,
  output logic progress_o,
  output logic any_empty_o,
  output logic all_fixed_o
);
  import sudoku_geom_pkg::*;

  row_sel_t sel_row;
  third_en_t sel_third;
  logic sel_mask_write;
  row_data_t sel_wdata;
  row_data_t row_read;

  cand_t cand [GRID_DIM][GRID_DIM];
  logic [NUM_CELLS-1:0] cell_progress;
  logic [NUM_CELLS-1:0] cell_fixed;
  logic [NUM_CELLS-1:0] cell_empty;

  // sweeper owns the grid for the whole solve
  assign sel_row = busy_i ? sweep.row_sel : host.row_sel;
  assign sel_third = busy_i ? sweep.third_en : host.third_en;
  assign sel_mask_write = busy_i ? sweep.mask_write : host.mask_write;
  assign sel_wdata = busy_i ? sweep.wdata : host.wdata;

  for (genvar r = 0; r < GRID_DIM; r++) begin : g_row
    for (genvar c = 0; c < GRID_DIM; c++) begin : g_col
      sudoku_cell u_cell (
        .clk              (clk),
        .reset            (reset),
        .we_i             (sel_row[r] & sel_third[c / BOX_DIM]),
        .mask_write_i     (sel_mask_write),
        .wdata_i          (sel_wdata[c]),
        .latch_progress_i (latch_progress_i),
        .cand_o           (cand[r][c]),
        .progress_o       (cell_progress[r * GRID_DIM + c]),
        .fixed_o          (cell_fixed[r * GRID_DIM + c]),
        .empty_o          (cell_empty[r * GRID_DIM + c])
      );
    end
  end

  // scan from the top so the lowest selected row is left on the bus
  always_comb begin
    row_read = '0;
    for (int r = GRID_DIM - 1; r >= 0; r--) begin
      if (sel_row[r]) begin
        for (int c = 0; c < GRID_DIM; c++) begin
          row_read[c] = cand[r][c];
        end
      end
    end
  end

  assign host.rdata = row_read;
  assign sweep.rdata = row_read;

  assign progress_o = |cell_progress;
  assign any_empty_o = |cell_empty;
  assign all_fixed_o = &cell_fixed;

endmodule

/* src/sudoku_cell.sv */
module sudoku_cell (
  input  logic clk,
  input  logic reset,
  input  logic we_i,
  input  logic mask_write_i,
  input  sudoku_geom_pkg::cand_t wdata_i,
  input  logic latch_progress_i,
  output sudoku_geom_pkg::cand_t cand_o,
  output logic progress_o,
  output logic fixed_o,
  output logic empty_o
);
  import sudoku_geom_pkg::*;

  cand_t cand_q;
  logic progress_q;
  logic strikes; // mask write that takes away at least one candidate

  assign fixed_o = $onehot(cand_q);
  assign empty_o = (cand_q == '0);

  assign strikes = we_i && mask_write_i && !fixed_o &&
                   ((cand_q & ~wdata_i) != '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      cand_q <= ALL_CANDIDATES;
    end else if (we_i) begin
      if (!mask_write_i) begin
        cand_q <= wdata_i;
      end else if (!fixed_o) begin
        cand_q <= cand_q & wdata_i; // a settled digit stays put
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset || latch_progress_i) begin
      progress_q <= 1'b0;
    end else if (strikes) begin
      progress_q <= 1'b1;
    end
  end

  assign cand_o = cand_q;
  assign progress_o = progress_q;

  // masking never moves a settled digit and every loss on an open cell raises progress
  a_fixed_kept: assert property (
    @(posedge clk) disable iff (reset)
    (we_i && mask_write_i) |=> $stable(cand_q) || (!$past(fixed_o) && progress_q)
  );

endmodule

/* src/grid_access_if.sv */
interface grid_access_if;
  import sudoku_geom_pkg::*;

  row_sel_t row_sel;
  third_en_t third_en;
  logic mask_write; // 0 loads, 1 removes candidates
  row_data_t wdata;
  row_data_t rdata; // combinational, lowest selected row

  modport sweeper (
    output row_sel,
    output third_en,
    output mask_write,
    output wdata,
    input  rdata
  );

  modport array (
    input  row_sel,
    input  third_en,
    input  mask_write,
    input  wdata,
    output rdata
  );

endinterface

/* src/solver_ctrl_pkg.sv */
package solver_ctrl_pkg;

  typedef enum logic [2:0] {
    S_IDLE,
    S_CHECK,     // look at progress flags, then clear them
    S_ROW_SCAN,  // read one row and accumulate masks
    S_ROW_SAVE,
    S_BOX_SAVE,  // three box masks into the current band
    S_COL_SAVE
  } sweep_state_t;

  // check, scan and save per row, one box save per band, one column save
  localparam int PASS_CYCLES =
    1 + 2 * sudoku_geom_pkg::GRID_DIM + sudoku_geom_pkg::BOX_DIM + 1;

  // last row of each band
  localparam sudoku_geom_pkg::row_sel_t BAND_LAST_ROWS = 9'b100_100_100;

endpackage

/* src/sudoku_geom_pkg.sv */
package sudoku_geom_pkg;

  // digits, rows and columns per side
  localparam int GRID_DIM = 9;
  localparam int BOX_DIM = 3;
  localparam int NUM_CELLS = GRID_DIM * GRID_DIM;

  // bit n set means digit n+1 is still possible
  typedef logic [GRID_DIM-1:0] cand_t;

  // nine cells of one row, column 0 in the low bits
  typedef cand_t [GRID_DIM-1:0] row_data_t;

  typedef logic [GRID_DIM-1:0] row_sel_t; // one-hot row enable

  // bit 0 covers columns 0 to 2
  typedef logic [BOX_DIM-1:0] third_en_t;

  typedef logic [$clog2(GRID_DIM)-1:0] row_addr_t;

  localparam cand_t ALL_CANDIDATES = '1;

endpackage
